/* list.f */
hw/cpuCtrlPkg.sv
hw/instrDecoder.sv
hw/condEvaluator.sv
hw/ctrlSequencer.sv
hw/cpuControl.sv
dv/cpuControl_checker.sv
dv/cpuControlTb.sv

/* Makefile */
# Verilator build and run of the cpuControl testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f list.f --top-module cpuControlTb -Mdir obj_dir

run: compile
	./obj_dir/VcpuControlTb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* dv/cpuControlTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuControlTb;
    import cpuCtrlPkg::*;

    localparam int clkPeriod    = 40;
    localparam int aluCount     = 40;
    localparam int cmpCount     = 16;
    localparam int memCount     = 20;
    localparam int jalCount     = 10;
    localparam int condCount    = 96; // six passes over the sixteen codes
    localparam int illegalCount = 16;
    localparam int instrTotal   = 1 + aluCount + cmpCount + memCount + jalCount
                                  + condCount + illegalCount;
    // longest instruction takes 8 cycles
    localparam int timeoutNs    = (instrTotal * 8 + 4) * clkPeriod + 2000;

    // step kinds of the reference sequence
    localparam int kFetch     = 0;
    localparam int kDecode    = 1;
    localparam int kLoad      = 2;
    localparam int kExec      = 3;
    localparam int kWriteBack = 4;
    localparam int kMemRead   = 5;
    localparam int kMemWrite  = 6;
    localparam int kLoadWb    = 7;
    localparam int kJalStore  = 8;
    localparam int kJalPc     = 9;
    localparam int kCondPc    = 10;
    localparam int kInc1      = 11;
    localparam int kInc2      = 12;
    localparam int kInc3      = 13;

    localparam instrClass aluMoveCls [4] = '{ALU_REG, ALU_IMM, MOV_REG, MOV_IMM};
    localparam logic [3:0] aluExts [6] = '{extAdd, extMul, extSub, extAnd, extOr, extXor};
    localparam logic [3:0] immOps [7] = '{opAddi, opSubi, opAndi, opOri, opXori, opLui, opModi};
    localparam logic [3:0] badOps [3] = '{4'b0111, 4'b1010, 4'b1110};
    localparam logic [3:0] badRegExts [8] = '{4'b0000, 4'b0100, 4'b0110, 4'b0111,
                                              4'b1000, 4'b1010, 4'b1100, 4'b1111};

    logic      clk;
    logic      reset;
    instrWord  instr;
    psrFlags   psr;
    ctrlWord   ctrl;

    integer    seed;
    int        steps[$];
    instrClass curCls;
    condCode   curCond;
    string     testName;
    string     label;
    int        checks;
    int        errors;
    int        testErrors;
    int        testsPassed;
    int        testsFailed;

    cpuControl UUT
    (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .psr   (psr),
        .ctrl  (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial
    begin
        #(timeoutNs);
        $display("timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic int pick(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic randomPsr();
        logic [31:0] r;
        r = $random(seed);
        psr = r[7:0]; // reserved bits get noise too
    endtask

    // taken rules per condition code
    function automatic logic condHolds(input condCode cc, input psrFlags p);
        logic t;
        case (cc)
            EQ:      t = p.z;
            NE:      t = !p.z;
            GE:      t = p.z || p.n;
            CS:      t = p.c;
            CC:      t = !p.c;
            HI:      t = p.l;
            LS:      t = !p.l;
            LO:      t = !p.l && !p.z;
            HS:      t = p.l || p.z;
            GT:      t = p.n;
            LE:      t = !p.n;
            FS:      t = p.f;
            FC:      t = !p.f;
            LT:      t = !p.n && !p.z;
            UC:      t = 1'b1;
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    function automatic ctrlWord expectedWord(input int kind, input instrClass c,
                                             input condCode cc, input psrFlags p);
        ctrlWord w;
        w = '0;
        case (kind)
            kFetch: w.instrWrite = 1'b1;
            kLoad:  w.newAluInput = 1'b1;
            kExec:
            begin
                w.aluSrc1Sel = (c == MOV_REG || c == MOV_IMM) ? SEL_ZERO : SEL_REG;
                if (c == ALU_IMM || c == CMP_IMM || c == MOV_IMM)
                    w.aluSrc2Sel = SEL_REG;
                if (c == CMP_REG || c == CMP_IMM)
                    w.psrRegEn = 1'b1;
            end
            kWriteBack: w.regWrite = 1'b1;
            kMemWrite:  w.memWrite = 1'b1;
            kLoadWb:
            begin
                w.writeBackSelect = 1'b1;
                w.regWrite        = 1'b1;
            end
            kJalStore:
            begin
                w.dataToWriteSelect = 1'b1;
                w.regWrite          = 1'b1;
            end
            kJalPc:
            begin
                w.pcEn  = 1'b1;
                w.pcSrc = PC_ABS;
            end
            kCondPc:
            begin
                w.pcEn = 1'b1; // not taken falls through to the next pc
                if (condHolds(cc, p))
                    w.pcSrc = (c == JCOND) ? PC_ABS : PC_REL;
            end
            kInc1:   w.pcEn = 1'b1;
            kInc3:   w.sendPcAddr = 1'b1;
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic buildSteps(input instrClass c, input condCode cc);
        steps.delete();
        steps.push_back(kFetch);
        steps.push_back(kDecode);
        if (c == ALU_REG || c == ALU_IMM || c == MOV_REG || c == MOV_IMM)
        begin
            steps.push_back(kLoad);
            steps.push_back(kExec);
            steps.push_back(kWriteBack);
        end
        else if (c == CMP_REG || c == CMP_IMM)
        begin
            steps.push_back(kLoad);
            steps.push_back(kExec);
        end
        else if (c == LOAD)
        begin
            steps.push_back(kLoad);
            steps.push_back(kMemRead);
            steps.push_back(kLoadWb);
        end
        else if (c == STORE)
        begin
            steps.push_back(kLoad);
            steps.push_back(kMemWrite);
        end
        else if (c == JAL)
        begin
            steps.push_back(kLoad);
            steps.push_back(kJalStore);
            steps.push_back(kJalPc);
        end
        // a condition cycle already writes the pc
        if ((c == JCOND || c == BCOND) && cc != NEVER)
            steps.push_back(kCondPc);
        else
            steps.push_back(kInc1);
        steps.push_back(kInc2);
        steps.push_back(kInc3);
    endtask

    task automatic loadInstr(input instrClass c, input condCode cc);
        instrWord    w;
        logic [31:0] r;
        r = $random(seed);
        w = r[15:0]; // random register fields and immediate
        case (c)
            ALU_REG:
            begin
                w.regForm.op    = r[16] ? opLsh : opRegAlu;
                w.regForm.opExt = r[16] ? extLsh : aluExts[pick(6)];
            end
            ALU_IMM:
            begin
                if (r[16])
                begin
                    w.regForm.op = opLsh; // LSHI, any opExt but the register shift
                    if (w.regForm.opExt == extLsh)
                        w.regForm.opExt = 4'b0000;
                end
                else
                    w.immForm.op = immOps[pick(7)];
            end
            CMP_REG: w.regForm = '{opRegAlu, r[11:8], extCmp, r[3:0]};
            CMP_IMM: w.immForm.op = opCmpi;
            MOV_REG: w.regForm = '{opRegAlu, r[11:8], extMov, r[3:0]};
            MOV_IMM: w.immForm.op = opMovi;
            LOAD:    w.regForm = '{opMem, r[11:8], extLoad, r[3:0]};
            STORE:   w.regForm = '{opMem, r[11:8], extStor, r[3:0]};
            JAL:     w.regForm = '{opMem, r[11:8], extJal, r[3:0]};
            JCOND:   w.regForm = '{opMem, cc, extJcond, r[3:0]};
            BCOND:   w.immForm = '{opBcond, cc, r[7:0]};
            default:
            begin
                case (pick(3))
                    0:       w.regForm.op = badOps[pick(3)];
                    1:       w.regForm = '{opRegAlu, r[11:8], badRegExts[pick(8)], r[3:0]};
                    default: w.regForm = '{opMem, r[11:8], r[19:16] | 4'b0001, r[3:0]};
                endcase
            end
        endcase
        instr   = w;
        curCls  = c;
        curCond = cc;
        label   = c.name();
    endtask

    task automatic compareWord(input int step, input ctrlWord expected);
        checks++;
        if (ctrl !== expected)
        begin
            $display("FAIL %s %s step %0d: expected %h actual %h",
                     testName, label, step, expected, ctrl);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkCount(input string what, input int expected, input int actual);
        checks++;
        if (actual != expected)
        begin
            $display("FAIL %s %s %s pulses: expected %0d actual %0d",
                     testName, label, what, expected, actual);
            errors++;
            testErrors++;
        end
    endtask

    // walk the model steps, one compare per cycle, then stop in the next FETCH
    task automatic playSteps(input int first);
        int regWrites;
        int psrWrites;
        int memWrites;
        int pcWrites;
        regWrites = 0;
        psrWrites = 0;
        memWrites = 0;
        pcWrites  = 0;
        for (int s = first; s < steps.size(); s++)
        begin
            if (s > 0)
            begin
                @(posedge clk);
                #2;
                randomPsr();
            end
            @(negedge clk);
            compareWord(s, expectedWord(steps[s], curCls, curCond, psr));
            if (ctrl.regWrite)
                regWrites++;
            if (ctrl.psrRegEn)
                psrWrites++;
            if (ctrl.memWrite)
                memWrites++;
            if (ctrl.pcEn)
                pcWrites++;
        end
        checkCount("regWrite", (curCls inside {ALU_REG, ALU_IMM, MOV_REG, MOV_IMM, LOAD, JAL})
                   ? 1 : 0, regWrites);
        checkCount("psrRegEn", (curCls inside {CMP_REG, CMP_IMM}) ? 1 : 0, psrWrites);
        checkCount("memWrite", (curCls == STORE) ? 1 : 0, memWrites);
        checkCount("pcEn", (curCls == JAL) ? 2 : 1, pcWrites); // JAL target, then increment
        @(posedge clk);
        #2;
    endtask

    task automatic runInstr(input instrClass c, input condCode cc);
        loadInstr(c, cc);
        randomPsr();
        buildSteps(c, cc);
        playSteps(0);
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0)
        begin
            testsPassed++;
            $display("test %s: passed", testName);
        end
        else
        begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, testErrors);
        end
    endtask

    initial
    begin
        seed        = 32'h31c8;
        reset       = 1'b0;
        instr       = '0;
        psr         = '0;
        checks      = 0;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        curCls      = ILLEGAL;
        curCond     = NEVER;

        startTest("resetState");
        label = "reset";
        @(posedge clk);
        #2;
        randomPsr();
        @(negedge clk);
        compareWord(0, expectedWord(kFetch, ILLEGAL, NEVER, psr));
        @(posedge clk);
        #2;
        reset = 1'b1;
        loadInstr(ALU_REG, NEVER); // first instruction starts in this FETCH
        randomPsr();
        buildSteps(ALU_REG, NEVER);
        @(negedge clk);
        compareWord(0, expectedWord(kFetch, ALU_REG, NEVER, psr));
        playSteps(1);
        endTest();

        startTest("aluAndMove");
        for (int i = 0; i < aluCount; i++)
            runInstr(aluMoveCls[pick(4)], NEVER);
        endTest();

        startTest("compare");
        for (int i = 0; i < cmpCount; i++)
            runInstr((pick(2) == 0) ? CMP_REG : CMP_IMM, NEVER);
        endTest();

        startTest("memory");
        for (int i = 0; i < memCount; i++)
            runInstr((pick(2) == 0) ? LOAD : STORE, NEVER);
        endTest();

        startTest("jumpAndLink");
        for (int i = 0; i < jalCount; i++)
            runInstr(JAL, NEVER);
        endTest();

        startTest("conditional");
        for (int i = 0; i < condCount; i++)
            runInstr(i[4] ? BCOND : JCOND, condCode'(i[3:0]));
        for (int i = 0; i < illegalCount; i++)
            runInstr(ILLEGAL, NEVER);
        label = "end";
        @(negedge clk);
        compareWord(0, expectedWord(kFetch, ILLEGAL, NEVER, psr));
        endTest();

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 testsPassed, testsFailed, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cpuControl_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrlChecker
(
    input wire                      clk,
    input wire                      reset,
    input wire cpuCtrlPkg::ctrlWord ctrl
);
    import cpuCtrlPkg::*;

    // a store cycle never writes the register file
    noWriteClash: assert property (@(posedge clk) disable iff (!reset)
        !(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite are high in the same cycle");

    idleDecode: assert property (@(posedge clk) disable iff (!reset)
        ctrl.instrWrite |=> (ctrl == '0)) // DECODE drives nothing
        else $error("the cycle after instrWrite is not an idle DECODE");

    seqWhenIdle: assert property (@(posedge clk) disable iff (!reset)
        !ctrl.pcEn |-> (ctrl.pcSrc == PC_SEQ))
        else $error("pcSrc is not PC_SEQ while pcEn is low");

    // fetch address goes out, then the instruction is captured
    fetchFollows: assert property (@(posedge clk) disable iff (!reset)
        ctrl.sendPcAddr |=> ctrl.instrWrite)
        else $error("sendPcAddr is not followed by instrWrite");

endmodule

bind cpuControl ctrlChecker ctrlCheck
(
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl)
);

`default_nettype wire

/* hw/cpuControl.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuControl
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpuCtrlPkg::instrWord  instr,
    input  wire cpuCtrlPkg::psrFlags   psr,
    output cpuCtrlPkg::ctrlWord        ctrl
);
    import cpuCtrlPkg::*;

    instrClass cls;
    condCode   cond;
    condCode   heldCond; // latched at DECODE
    logic      taken;

    instrDecoder decoder
    (
        .instr (instr),
        .cls   (cls),
        .cond  (cond)
    );

    condEvaluator evaluator
    (
        .heldCond (heldCond),
        .psr      (psr),
        .taken    (taken)
    );

    ctrlSequencer sequencer
    (
        .clk      (clk),
        .reset    (reset),
        .cls      (cls),
        .cond     (cond),
        .taken    (taken),
        .heldCond (heldCond),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

/* hw/ctrlSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrlSequencer
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire cpuCtrlPkg::instrClass  cls,
    input  wire cpuCtrlPkg::condCode    cond,
    input  wire                         taken,
    output cpuCtrlPkg::condCode         heldCond,
    output cpuCtrlPkg::ctrlWord         ctrl
);
    import cpuCtrlPkg::*;

    ctrlState state;
    ctrlState nextState;

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= FETCH;
        else
            state <= nextState;
    end

    // condition for the JCOND_EVAL / BCOND_EVAL cycle
    always_ff @(posedge clk)
    begin
        if (state == DECODE)
            heldCond <= cond;
    end

    always_comb
    begin
        nextState = PC_INCR;
        case (state)
            FETCH: nextState = DECODE;
            DECODE:
            begin
                case (cls)
                    ALU_REG: nextState = ALU_REG_LD;
                    ALU_IMM: nextState = ALU_IMM_LD;
                    CMP_REG: nextState = CMP_REG_LD;
                    CMP_IMM: nextState = CMP_IMM_LD;
                    MOV_REG: nextState = MOV_REG_LD;
                    MOV_IMM: nextState = MOV_IMM_LD;
                    LOAD:    nextState = LOAD_LD;
                    STORE:   nextState = STORE_LD;
                    JAL:     nextState = JAL_REG;
                    JCOND:   nextState = (cond == NEVER) ? PC_INCR : JCOND_EVAL;
                    BCOND:   nextState = (cond == NEVER) ? PC_INCR : BCOND_EVAL;
                    default: nextState = PC_INCR; // undecodable, skip it
                endcase
            end
            ALU_REG_LD:   nextState = ALU_REG_EX;
            ALU_IMM_LD:   nextState = ALU_IMM_EX;
            MOV_REG_LD:   nextState = MOV_REG_EX;
            MOV_IMM_LD:   nextState = MOV_IMM_EX;
            ALU_REG_EX, ALU_IMM_EX, MOV_REG_EX, MOV_IMM_EX:
                nextState = WRITEBACK;
            WRITEBACK:    nextState = PC_INCR;
            CMP_REG_LD:   nextState = CMP_REG_EX;
            CMP_IMM_LD:   nextState = CMP_IMM_EX;
            CMP_REG_EX, CMP_IMM_EX:
                nextState = PC_INCR;
            LOAD_LD:      nextState = MEM_READ;
            MEM_READ:     nextState = LOAD_WB;
            LOAD_WB:      nextState = PC_INCR;
            STORE_LD:     nextState = MEM_WRITE;
            MEM_WRITE:    nextState = PC_INCR;
            JAL_REG:      nextState = JAL_STORE_PC;
            JAL_STORE_PC: nextState = JAL_NEW_PC;
            JAL_NEW_PC:   nextState = PC_INCR;
            JCOND_EVAL, BCOND_EVAL:
                nextState = PC_INCR2; // pc already written
            PC_INCR:      nextState = PC_INCR2;
            PC_INCR2:     nextState = PC_INCR3;
            PC_INCR3:     nextState = FETCH;
            default:      nextState = PC_INCR;
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        case (state)
            FETCH: ctrl.instrWrite = 1'b1;
            ALU_REG_LD, ALU_IMM_LD, CMP_REG_LD, CMP_IMM_LD,
            MOV_REG_LD, MOV_IMM_LD, LOAD_LD, STORE_LD, JAL_REG:
                ctrl.newAluInput = 1'b1;
            ALU_REG_EX: ctrl.aluSrc1Sel = SEL_REG;
            ALU_IMM_EX:
            begin
                ctrl.aluSrc1Sel = SEL_REG;
                ctrl.aluSrc2Sel = SEL_REG;
            end
            CMP_REG_EX:
            begin
                ctrl.aluSrc1Sel = SEL_REG;
                ctrl.psrRegEn   = 1'b1;
            end
            CMP_IMM_EX:
            begin
                ctrl.aluSrc1Sel = SEL_REG;
                ctrl.aluSrc2Sel = SEL_REG;
                ctrl.psrRegEn   = 1'b1;
            end
            MOV_REG_EX: ctrl.aluSrc1Sel = SEL_ZERO; // source plus zero
            MOV_IMM_EX:
            begin
                ctrl.aluSrc1Sel = SEL_ZERO;
                ctrl.aluSrc2Sel = SEL_REG;
            end
            WRITEBACK: ctrl.regWrite = 1'b1;
            MEM_WRITE: ctrl.memWrite = 1'b1;
            LOAD_WB:
            begin
                ctrl.writeBackSelect = 1'b1; // memory data to register file
                ctrl.regWrite        = 1'b1;
            end
            JAL_STORE_PC:
            begin
                ctrl.dataToWriteSelect = 1'b1; // return address
                ctrl.regWrite          = 1'b1;
            end
            JAL_NEW_PC:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = PC_ABS;
            end
            JCOND_EVAL:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = taken ? PC_ABS : PC_SEQ;
            end
            BCOND_EVAL:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = taken ? PC_REL : PC_SEQ;
            end
            PC_INCR:  ctrl.pcEn = 1'b1;
            PC_INCR3: ctrl.sendPcAddr = 1'b1; // next fetch address out
            default:  ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/condEvaluator.sv */
`timescale 1ns/100ps
`default_nettype none

module condEvaluator
(
    input  wire cpuCtrlPkg::condCode heldCond,
    input  wire cpuCtrlPkg::psrFlags psr,
    output logic                     taken
);
    import cpuCtrlPkg::*;

    always_comb
    begin
        case (heldCond)
            EQ:      taken = psr.z;
            NE:      taken = ~psr.z;
            GE:      taken = psr.z | psr.n;
            CS:      taken = psr.c;
            CC:      taken = ~psr.c;
            HI:      taken = psr.l;
            LS:      taken = ~psr.l;
            LO:      taken = ~(psr.l | psr.z);
            HS:      taken = psr.l | psr.z;
            GT:      taken = psr.n;
            LE:      taken = ~psr.n;
            FS:      taken = psr.f;
            FC:      taken = ~psr.f;
            LT:      taken = ~(psr.n | psr.z);
            UC:      taken = 1'b1;
            default: taken = 1'b0; // never
        endcase
    end

endmodule

`default_nettype wire

/* hw/instrDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instrDecoder
(
    input  wire cpuCtrlPkg::instrWord  instr,
    output cpuCtrlPkg::instrClass      cls,
    output cpuCtrlPkg::condCode        cond
);
    import cpuCtrlPkg::*;

    logic regFormOp; // low byte holds opExt and rSrc

    assign regFormOp = (instr.regForm.op == opRegAlu) ||
                       (instr.regForm.op == opMem) ||
                       (instr.regForm.op == opLsh);

    // Jcond and Bcond carry their condition in the destination field
    assign cond = condCode'(instr.regForm.rDest);

    always_comb
    begin
        cls = ILLEGAL;
        if (regFormOp)
        begin
            case (instr.regForm.op)
                opRegAlu:
                begin
                    case (instr.regForm.opExt)
                        extAdd, extSub, extAnd, extOr, extXor, extMul: cls = ALU_REG;
                        extCmp:  cls = CMP_REG;
                        extMov:  cls = MOV_REG;
                        default: cls = ILLEGAL;
                    endcase
                end
                opMem:
                begin
                    case (instr.regForm.opExt)
                        extLoad:  cls = LOAD;
                        extStor:  cls = STORE;
                        extJal:   cls = JAL;
                        extJcond: cls = JCOND; // absolute target
                        default:  cls = ILLEGAL;
                    endcase
                end
                default:
                begin
                    // shift by register or by immediate
                    if (instr.regForm.opExt == extLsh)
                        cls = ALU_REG;
                    else
                        cls = ALU_IMM;
                end
            endcase
        end
        else
        begin
            case (instr.immForm.op)
                opAddi, opSubi, opAndi, opOri, opXori, opLui, opModi: cls = ALU_IMM;
                opCmpi:  cls = CMP_IMM;
                opMovi:  cls = MOV_IMM;
                opBcond: cls = BCOND; // pc relative
                default: cls = ILLEGAL;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

    // register form, opcodes 0000, 0100 and 1000
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] rDest;
        logic [3:0] opExt;
        logic [3:0] rSrc;
    } regFields;

    // immediate form, every other opcode
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] rDest;
        logic [7:0] imm;
    } immFields;

    typedef union packed {
        regFields regForm;
        immFields immForm;
    } instrWord;

    // major opcodes
    localparam logic [3:0] opRegAlu = 4'b0000;
    localparam logic [3:0] opLsh    = 4'b1000; // LSH or LSHI, split by opExt
    localparam logic [3:0] opMem    = 4'b0100;
    localparam logic [3:0] opAddi   = 4'b0101;
    localparam logic [3:0] opSubi   = 4'b1001;
    localparam logic [3:0] opCmpi   = 4'b1011;
    localparam logic [3:0] opAndi   = 4'b0001;
    localparam logic [3:0] opOri    = 4'b0010;
    localparam logic [3:0] opXori   = 4'b0011;
    localparam logic [3:0] opMovi   = 4'b1101;
    localparam logic [3:0] opLui    = 4'b1111;
    localparam logic [3:0] opModi   = 4'b0110;
    localparam logic [3:0] opBcond  = 4'b1100;

    // opExt codes under opRegAlu
    localparam logic [3:0] extAdd   = 4'b0101;
    localparam logic [3:0] extMul   = 4'b1110;
    localparam logic [3:0] extSub   = 4'b1001;
    localparam logic [3:0] extCmp   = 4'b1011;
    localparam logic [3:0] extAnd   = 4'b0001;
    localparam logic [3:0] extOr    = 4'b0010;
    localparam logic [3:0] extXor   = 4'b0011;
    localparam logic [3:0] extMov   = 4'b1101;

    // opExt codes under opMem
    localparam logic [3:0] extLoad  = 4'b0000;
    localparam logic [3:0] extStor  = 4'b0100;
    localparam logic [3:0] extJal   = 4'b1000;
    localparam logic [3:0] extJcond = 4'b1100;

    localparam logic [3:0] extLsh   = 4'b0100; // under opLsh, register shift

    typedef enum logic [3:0] {
        EQ    = 4'b0000,
        NE    = 4'b0001,
        CS    = 4'b0010,
        CC    = 4'b0011,
        HI    = 4'b0100,
        LS    = 4'b0101,
        GT    = 4'b0110,
        LE    = 4'b0111,
        FS    = 4'b1000,
        FC    = 4'b1001,
        LO    = 4'b1010,
        HS    = 4'b1011,
        LT    = 4'b1100,
        GE    = 4'b1101,
        UC    = 4'b1110,
        NEVER = 4'b1111
    } condCode;

    typedef struct packed {
        logic [2:0] reserved;
        logic       c; // carry
        logic       l; // unsigned greater
        logic       f; // flag
        logic       z; // equal
        logic       n; // signed greater
    } psrFlags;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, CMP_REG, CMP_IMM, MOV_REG, MOV_IMM,
        LOAD, STORE, JAL, JCOND, BCOND, ILLEGAL
    } instrClass;

    typedef enum logic [4:0] {
        FETCH, DECODE,
        ALU_REG_LD, ALU_REG_EX, ALU_IMM_LD, ALU_IMM_EX,
        CMP_REG_LD, CMP_REG_EX, CMP_IMM_LD, CMP_IMM_EX,
        MOV_REG_LD, MOV_REG_EX, MOV_IMM_LD, MOV_IMM_EX,
        LOAD_LD, STORE_LD,
        WRITEBACK, MEM_READ, MEM_WRITE, LOAD_WB,
        JAL_REG, JAL_STORE_PC, JAL_NEW_PC,
        JCOND_EVAL, BCOND_EVAL,
        PC_INCR, PC_INCR2, PC_INCR3
    } ctrlState;

    typedef enum logic [1:0] {
        PC_SEQ = 2'b00,
        PC_ABS = 2'b01,
        PC_REL = 2'b10
    } pcSource;

    typedef enum logic [1:0] {
        SEL_DEFAULT = 2'b00,
        SEL_REG     = 2'b01,
        SEL_ZERO    = 2'b10
    } aluSel;

    typedef struct packed {
        logic    instrWrite;
        logic    newAluInput;
        logic    psrRegEn;
        logic    regWrite;
        logic    writeBackSelect;
        logic    dataToWriteSelect;
        logic    memWrite;
        logic    pcEn;
        logic    sendPcAddr;
        aluSel   aluSrc1Sel;
        aluSel   aluSrc2Sel;
        pcSource pcSrc;
    } ctrlWord;

endpackage

`default_nettype wire
